//--- Bender.yml
package:
  name: gpio_tcb

sources:
  # packages first, then the design bottom up
  - files:
      - rtl/tcb_pkg.sv
      - rtl/gpio_pkg.sv
      - rtl/gpio_input_sync.sv
      - rtl/gpio_ctrl.sv
      - rtl/gpio_bank_demux.sv
      - rtl/gpio_top.sv

  # testbench, top module gpio_tb
  - target: test
    files:
      - verif/gpio_tb.sv

//--- rtl/gpio_bank_demux.sv
//////////////////////////////
// bank select for the shared bus port
// steers each strobe by the address bank bit and
// muxes the read data back, purely combinational
//////////////////////////////

`default_nettype none

module gpio_bank_demux (
  // shared bus side
  input  tcb_pkg::tcb_wr_req_t                           wr_req,
  input  tcb_pkg::tcb_rd_req_t                           rd_req,
  output tcb_pkg::tcb_rd_rsp_t                           rd_rsp,
  // per bank side
  output tcb_pkg::tcb_wr_req_t [gpio_pkg::gpio_banks-1:0] bank_wr_req,
  output tcb_pkg::tcb_rd_req_t [gpio_pkg::gpio_banks-1:0] bank_rd_req,
  input  tcb_pkg::tcb_rd_rsp_t [gpio_pkg::gpio_banks-1:0] bank_rd_rsp
);

  import gpio_pkg::*;

  // one hot bank hit per channel
  logic [gpio_banks-1:0] wr_sel;
  logic [gpio_banks-1:0] rd_sel;

  //////////////////////////////
  // bank decode
  //////////////////////////////

  always_comb begin
    for (int unsigned b = 0; b < gpio_banks; b++) begin
      // bank bit compared against the bank index
      wr_sel[b] = (wr_req.adr.bank == 1'(b));
      rd_sel[b] = (rd_req.adr.bank == 1'(b));
    end
  end

  //////////////////////////////
  // request fan out
  //////////////////////////////

  always_comb begin
    for (int unsigned b = 0; b < gpio_banks; b++) begin
      // address and data go to every bank
      bank_wr_req[b] = wr_req;
      bank_rd_req[b] = rd_req;
      // only the strobe is gated
      bank_wr_req[b].vld = wr_req.vld & wr_sel[b];
      bank_rd_req[b].vld = rd_req.vld & rd_sel[b];
    end
  end

  //////////////////////////////
  // read data return
  //////////////////////////////

  // addressed bank, even when vld is low
  assign rd_rsp = bank_rd_rsp[rd_req.adr.bank];

endmodule

`default_nettype wire

//--- rtl/gpio_ctrl.sv
//////////////////////////////
// one gpio bank on the split read/write bus
// holds the output and enable registers, decodes
// writes by offset and serves reads in the same cycle
// the bank field is resolved upstream
//////////////////////////////

`default_nettype none

module gpio_ctrl (
  input  logic                         tcb_rdc,
  input  logic                         rst_n,
  // bus channels, already gated to this bank
  input  tcb_pkg::tcb_wr_req_t         wr_req,
  input  tcb_pkg::tcb_rd_req_t         rd_req,
  output tcb_pkg::tcb_rd_rsp_t         rd_rsp,
  // pins
  input  logic [gpio_pkg::gpio_w-1:0]  gpio_i,
  output gpio_pkg::gpio_pad_t          pad
);

  import tcb_pkg::*;
  import gpio_pkg::*;

  // pins after the synchronizer
  logic [gpio_w-1:0] pin_sync;

  //////////////////////////////
  // input path
  //////////////////////////////

  gpio_input_sync #(
    .stages (gpio_cdc_stages)
  ) gpio_input_sync_inst (
    .tcb_rdc (tcb_rdc),
    .rst_n   (rst_n),
    .pin     (gpio_i),
    .sync    (pin_sync)
  );

  //////////////////////////////
  // write access
  //////////////////////////////

  // register updates on the strobe edge
  // pad follows right after that edge
  always_ff @(posedge tcb_rdc) begin
    if (!rst_n) begin
      pad.o <= '0;
      pad.e <= '0;
    end else if (wr_req.vld) begin
      // no byte enables, only low pin bits kept
      case (wr_req.adr.ofs)
        gpio_reg_out: pad.o <= wr_req.wdt[gpio_w-1:0];
        gpio_reg_ena: pad.e <= wr_req.wdt[gpio_w-1:0];
        // input register and holes are read only
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // read access
  //////////////////////////////

  // decode runs regardless of vld
  // same cycle write is not yet visible here
  always_comb begin
    case (rd_req.adr.ofs)
      gpio_reg_out: rd_rsp.rdt = tcb_dat_w'(pad.o);
      gpio_reg_ena: rd_rsp.rdt = tcb_dat_w'(pad.e);
      gpio_reg_in:  rd_rsp.rdt = tcb_dat_w'(pin_sync);
      // unmapped offsets
      default:      rd_rsp.rdt = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/gpio_input_sync.sv
//////////////////////////////
// register chain for asynchronous pin inputs
// brings a bank's pin word into the bus clock domain
// stages = 0 passes the pins straight through
//////////////////////////////

`default_nettype none

module gpio_input_sync #(
  parameter int unsigned stages = gpio_pkg::gpio_cdc_stages
) (
  input  logic                            tcb_rdc,
  input  logic                            rst_n,
  input  logic [gpio_pkg::gpio_w-1:0]     pin,
  output logic [gpio_pkg::gpio_w-1:0]     sync
);

  import gpio_pkg::*;

  if (stages == 0) begin : gen_bypass

    // no chain, pins used as they are
    assign sync = pin;

  end else begin : gen_chain

    // stage 0 samples the raw pins
    logic [stages-1:0][gpio_w-1:0] chain;

    always_ff @(posedge tcb_rdc) begin
      if (!rst_n) begin
        chain <= '0;
      end else begin
        chain[0] <= pin;
        // shift towards the last stage
        for (int unsigned i = 1; i < stages; i++) begin
          chain[i] <= chain[i-1];
        end
      end
    end

    // last stage is the stable value
    assign sync = chain[stages-1];

  end

endmodule

`default_nettype wire

//--- rtl/gpio_pkg.sv
//////////////////////////////
// gpio side definitions
// pin width, bank count, register map, input
// synchronizer depth and the per bank pad controls
//////////////////////////////

`default_nettype none

package gpio_pkg;

  // pins per bank
  localparam int unsigned gpio_w = 16;

  // banks behind the shared bus port
  localparam int unsigned gpio_banks = 2;

  // input synchronizer depth
  // 0 bypasses the chain
  localparam int unsigned gpio_cdc_stages = 2;

  //////////////////////////////
  // register map
  //////////////////////////////

  // offsets within one bank, low address nibble
  localparam logic [3:0] gpio_reg_out = 4'h0;
  localparam logic [3:0] gpio_reg_ena = 4'h4;
  localparam logic [3:0] gpio_reg_in  = 4'h8;

  // pad controls of one bank
  // o drives the pin level, e enables the driver
  typedef struct packed {
    logic [gpio_w-1:0] o;
    logic [gpio_w-1:0] e;
  } gpio_pad_t;

endpackage

`default_nettype wire

//--- rtl/gpio_top.sv
//////////////////////////////
// gpio subsystem top level
// one split read/write bus port in front of
// gpio_banks bank controllers, address bit 4 picks the bank
//////////////////////////////

`default_nettype none

module gpio_top (
  input  logic                                             tcb_rdc,
  input  logic                                             rst_n,
  // bus port
  input  tcb_pkg::tcb_wr_req_t                             wr_req,
  input  tcb_pkg::tcb_rd_req_t                             rd_req,
  output tcb_pkg::tcb_rd_rsp_t                             rd_rsp,
  // pins, one word per bank
  input  logic [gpio_pkg::gpio_banks-1:0][gpio_pkg::gpio_w-1:0] gpio_i,
  output gpio_pkg::gpio_pad_t [gpio_pkg::gpio_banks-1:0]   pad
);

  import tcb_pkg::*;
  import gpio_pkg::*;

  // per bank channels between demux and controllers
  tcb_wr_req_t [gpio_banks-1:0] bank_wr_req;
  tcb_rd_req_t [gpio_banks-1:0] bank_rd_req;
  tcb_rd_rsp_t [gpio_banks-1:0] bank_rd_rsp;

  //////////////////////////////
  // bank select
  //////////////////////////////

  gpio_bank_demux gpio_bank_demux_inst (
    .wr_req      (wr_req),
    .rd_req      (rd_req),
    .rd_rsp      (rd_rsp),
    .bank_wr_req (bank_wr_req),
    .bank_rd_req (bank_rd_req),
    .bank_rd_rsp (bank_rd_rsp)
  );

  //////////////////////////////
  // bank controllers
  //////////////////////////////

  for (genvar b = 0; b < gpio_banks; b++) begin : gen_bank
    gpio_ctrl gpio_ctrl_inst (
      .tcb_rdc (tcb_rdc),
      .rst_n   (rst_n),
      .wr_req  (bank_wr_req[b]),
      .rd_req  (bank_rd_req[b]),
      .rd_rsp  (bank_rd_rsp[b]),
      .gpio_i  (gpio_i[b]),
      .pad     (pad[b])
    );
  end

endmodule

`default_nettype wire

//--- rtl/tcb_pkg.sv
//////////////////////////////
// bus side definitions for the gpio subsystem
// widths, the address word layout and the independent
// read and write channel structs
// import inside a module body, scoped names in ports
//////////////////////////////

`default_nettype none

package tcb_pkg;

  // bus widths
  localparam int unsigned tcb_adr_w = 8;
  localparam int unsigned tcb_dat_w = 32;

  // address word, msb first
  // upr is ignored by the decode
  typedef struct packed {
    logic [tcb_adr_w-6:0] upr;
    logic                 bank;
    logic [3:0]           ofs;
  } tcb_adr_t;

  // write channel, one transfer per cycle with vld high
  typedef struct packed {
    logic                 vld;
    tcb_adr_t             adr;
    logic [tcb_dat_w-1:0] wdt;
  } tcb_wr_req_t;

  // read channel request
  typedef struct packed {
    logic     vld;
    tcb_adr_t adr;
  } tcb_rd_req_t;

  // read data, same cycle as the request
  typedef struct packed {
    logic [tcb_dat_w-1:0] rdt;
  } tcb_rd_rsp_t;

endpackage

`default_nettype wire

//--- tb.f
rtl/tcb_pkg.sv
rtl/gpio_pkg.sv
rtl/gpio_input_sync.sv
rtl/gpio_ctrl.sv
rtl/gpio_bank_demux.sv
rtl/gpio_top.sv
verif/gpio_tb.sv

//--- verif/gpio_tb.sv
//////////////////////////////
// testbench for the gpio subsystem
// random bus traffic and pin words from a fixed seed
// checked against a per bank register model
// top module gpio_tb, sources in tb.f
//////////////////////////////

`default_nettype none

module gpio_tb;

  import tcb_pkg::*;
  import gpio_pkg::*;

  logic                              tcb_rdc;
  logic                              rst_n;
  tcb_wr_req_t                       wr_req;
  tcb_rd_req_t                       rd_req;
  tcb_rd_rsp_t                       rd_rsp;
  logic [gpio_banks-1:0][gpio_w-1:0] gpio_i;
  gpio_pad_t [gpio_banks-1:0]        pad;

  // reference model with one entry per bank
  logic [gpio_w-1:0] mdl_o   [gpio_banks];
  logic [gpio_w-1:0] mdl_e   [gpio_banks];
  logic [gpio_w-1:0] mdl_pin [gpio_banks];
  logic [31:0]       lcg_state;

  gpio_top gpio_top_inst (
    .tcb_rdc (tcb_rdc),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp),
    .gpio_i  (gpio_i),
    .pad     (pad)
  );

  initial begin
    tcb_rdc = 1'b0;
    forever #5 tcb_rdc = ~tcb_rdc;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // one lcg step
  // callers take the upper bits
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input tcb_rd_rsp_t got, input tcb_rd_rsp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got.rdt, exp.rdt));
    end
  endtask

  task automatic check_pad(input string name, input gpio_pad_t got, input gpio_pad_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s got o=%h e=%h expected o=%h e=%h",
                              name, got.o, got.e, exp.o, exp.e));
    end
  endtask

  // inputs change 1 unit after the edge
  task automatic next_cycle();
    @(posedge tcb_rdc);
    #1;
  endtask

  // register map applied to the model
  function automatic tcb_rd_rsp_t expected_read(input logic bank, input logic [3:0] ofs);
    tcb_rd_rsp_t rsp;
    rsp.rdt = '0;
    case (ofs)
      gpio_reg_out: rsp.rdt[gpio_w-1:0] = mdl_o[bank];
      gpio_reg_ena: rsp.rdt[gpio_w-1:0] = mdl_e[bank];
      gpio_reg_in:  rsp.rdt[gpio_w-1:0] = mdl_pin[bank];
      default:      rsp.rdt = '0;
    endcase
    return rsp;
  endfunction

  function automatic gpio_pad_t model_pad(input int b);
    gpio_pad_t p;
    p.o = mdl_o[b];
    p.e = mdl_e[b];
    return p;
  endfunction

  task automatic check_all_pads();
    for (int b = 0; b < gpio_banks; b++) begin
      check_pad($sformatf("pad[%0d]", b), pad[b], model_pad(b));
    end
  endtask

  // only out and ena are writable
  // low pin bits kept
  task automatic update_model(input logic bank, input logic [3:0] ofs, input logic [31:0] wdt);
    if (ofs == gpio_reg_out) begin
      mdl_o[bank] = wdt[gpio_w-1:0];
    end else if (ofs == gpio_reg_ena) begin
      mdl_e[bank] = wdt[gpio_w-1:0];
    end
  endtask

  //////////////////////////////
  // bus transfers
  //////////////////////////////

  // consecutive calls give back to back strobes
  task automatic bus_write(input logic bank, input logic [3:0] ofs, input logic [31:0] wdt);
    logic [31:0] r;
    r = rand32();
    wr_req.adr.upr  = r[31:29];
    wr_req.adr.bank = bank;
    wr_req.adr.ofs  = ofs;
    wr_req.wdt      = wdt;
    wr_req.vld      = 1'b1;
    next_cycle();
    wr_req.vld = 1'b0;
    update_model(bank, ofs, wdt);
    check_all_pads();
  endtask

  // zero latency read sampled mid cycle
  task automatic bus_read_check(input logic bank, input logic [3:0] ofs);
    logic [31:0] r;
    r = rand32();
    rd_req.adr.upr  = r[31:29];
    rd_req.adr.bank = bank;
    rd_req.adr.ofs  = ofs;
    rd_req.vld      = 1'b1;
    #1;
    check_rsp($sformatf("rd_rsp bank %0d ofs %h", bank, ofs), rd_rsp,
              expected_read(bank, ofs));
    next_cycle();
    rd_req.vld = 1'b0;
  endtask

  // read sees the old value and pad the new one after the edge
  task automatic read_during_write(input logic bank, input logic [3:0] ofs,
                                   input logic [31:0] wdt);
    wr_req.adr = '{upr: '0, bank: bank, ofs: ofs};
    wr_req.wdt = wdt;
    wr_req.vld = 1'b1;
    rd_req.adr = '{upr: '1, bank: bank, ofs: ofs};
    rd_req.vld = 1'b1;
    #1;
    check_rsp("rd_rsp during write", rd_rsp, expected_read(bank, ofs));
    next_cycle();
    wr_req.vld = 1'b0;
    rd_req.vld = 1'b0;
    update_model(bank, ofs, wdt);
    check_all_pads();
  endtask

  // new pin words held 4 cycles before the offset 8 reads
  task automatic apply_pins();
    logic [31:0] r;
    int unsigned waited;
    for (int b = 0; b < gpio_banks; b++) begin
      r = rand32();
      gpio_i[b] = r[31:16];
    end
    waited = 0;
    rd_req.adr = '{upr: '0, bank: 1'b0, ofs: gpio_reg_in};
    rd_req.vld = 1'b1;
    // let the read decode settle before sampling
    #1;
    while (rd_rsp.rdt !== tcb_dat_w'(gpio_i[0])) begin
      if (waited >= gpio_cdc_stages + 1) begin
        stop_on_error("input synchronizer did not pass the pin word in time");
      end else begin
        next_cycle();
        waited++;
      end
    end
    rd_req.vld = 1'b0;
    while (waited < 4) begin
      next_cycle();
      waited++;
    end
    for (int b = 0; b < gpio_banks; b++) begin
      mdl_pin[b] = gpio_i[b];
    end
    for (int b = 0; b < gpio_banks; b++) begin
      bus_read_check(1'(b), gpio_reg_in);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [31:0] r;
    logic [3:0]  ofs;
    lcg_state = 32'h45917fbe;
    rst_n     = 1'b0;
    wr_req    = '0;
    rd_req    = '0;
    gpio_i    = '0;
    for (int b = 0; b < gpio_banks; b++) begin
      mdl_o[b]   = '0;
      mdl_e[b]   = '0;
      mdl_pin[b] = '0;
    end
    repeat (3) @(posedge tcb_rdc);
    #1;
    rst_n = 1'b1;

    // reset state
    check_all_pads();
    for (int b = 0; b < gpio_banks; b++) begin
      bus_read_check(1'(b), gpio_reg_out);
      bus_read_check(1'(b), gpio_reg_ena);
    end

    // random writes and readback of out and ena
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      bus_write(r[31], r[30] ? gpio_reg_ena : gpio_reg_out, rand32());
      r = rand32();
      bus_read_check(r[31], r[30] ? gpio_reg_ena : gpio_reg_out);
    end

    // holes in the register map
    for (int i = 0; i < 30; i++) begin
      r   = rand32();
      ofs = r[27:24];
      if (ofs != gpio_reg_out && ofs != gpio_reg_ena) begin
        bus_write(r[31], ofs, rand32());
      end
      ofs = r[23:20];
      if (ofs != gpio_reg_out && ofs != gpio_reg_ena && ofs != gpio_reg_in) begin
        bus_read_check(r[30], ofs);
      end
    end

    // pin input path
    for (int i = 0; i < 6; i++) begin
      apply_pins();
    end

    // same cycle read and write
    for (int i = 0; i < 12; i++) begin
      r = rand32();
      read_during_write(r[31], r[30] ? gpio_reg_ena : gpio_reg_out, rand32());
    end

    // write burst with a strobe in every cycle
    for (int i = 0; i < 16; i++) begin
      r = rand32();
      bus_write(r[31], r[30] ? gpio_reg_ena : gpio_reg_out, rand32());
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
